// File: filelist.f
verilog/trc_pkg.sv
verilog/trc_axil_regs.sv
verilog/trc_db_request.sv
verilog/trc_db_response.sv
verilog/srio_trc_top.sv
verif/trc_tb.sv

// File: verif/trc_tb.sv
`timescale 1ns/1ns

module trc_tb
    import trc_pkg::*;
();

    localparam int          WAIT_LIMIT = 50;
    localparam logic [31:0] LFSR_SEED  = 32'h21ed_7d1a;
    localparam logic [31:0] LFSR_MASK  = 32'h8020_0003;

    logic                 aclk;
    logic                 aresetn;
    logic [AXIL_AW-1:0]   s_axil_awaddr;
    logic [2:0]           s_axil_awprot;
    logic                 s_axil_awvalid;
    logic                 s_axil_awready;
    logic [AXIL_DW-1:0]   s_axil_wdata;
    logic [AXIL_DW/8-1:0] s_axil_wstrb;
    logic                 s_axil_wvalid;
    logic                 s_axil_wready;
    logic [1:0]           s_axil_bresp;
    logic                 s_axil_bvalid;
    logic                 s_axil_bready;
    logic [AXIL_AW-1:0]   s_axil_araddr;
    logic [2:0]           s_axil_arprot;
    logic                 s_axil_arvalid;
    logic                 s_axil_arready;
    logic [AXIL_DW-1:0]   s_axil_rdata;
    logic [1:0]           s_axil_rresp;
    logic                 s_axil_rvalid;
    logic                 s_axil_rready;
    logic                 ireq_tvalid;
    logic                 ireq_tready;
    srio_beat_t           ireq_beat;
    logic                 iresp_tvalid;
    logic                 iresp_tready;
    srio_beat_t           iresp_beat;

    logic [31:0] lfsr_state;
    int          mismatch_errs;
    int          protocol_errs;
    int          timeout_errs;
    int          ireq_count;
    logic [15:0] info_model;
    logic [31:0] rd_val;
    logic [31:0] wr_val;
    srio_beat_t  got_beat;

    srio_trc_top u_dut (.*);

    initial begin
        aclk = 1'b0;
        forever begin
            #10 aclk = ~aclk;
        end
    end

    //////////////////////////////////////////////////
    // reporting and random bits
    //////////////////////////////////////////////////

    function automatic void protocol_fail(input string what);
        protocol_errs++;
        $display("protocol error at %0t: %s", $time, what);
    endfunction

    function automatic void wait_expired(input string what);
        timeout_errs++;
        $display("timeout at %0t: %s", $time, what);
    endfunction

    function automatic void check_value(input string name, input logic [63:0] exp,
                                        input logic [63:0] act);
        assert (act === exp) else begin
            mismatch_errs++;
            $display("mismatch %s: expected %h, actual %h", name, exp, act);
        end
    endfunction

    // galois lfsr, one step per bit
    function automatic logic [31:0] rand_bits(input int nbits);
        logic [31:0] val;
        int          i;
        val = '0;
        for (i = 0; i < nbits; i++) begin
            val = {val[30:0], lfsr_state[0]};
            lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ LFSR_MASK) : (lfsr_state >> 1);
        end
        return val;
    endfunction

    //////////////////////////////////////////////////
    // protocol checks
    //////////////////////////////////////////////////

    awready_once: assert property (@(posedge aclk) disable iff (!aresetn)
        s_axil_awready |=> !s_axil_awready) else protocol_fail("awready high two cycles");
    wready_once: assert property (@(posedge aclk) disable iff (!aresetn)
        s_axil_wready |=> !s_axil_wready) else protocol_fail("wready high two cycles");
    aw_w_together: assert property (@(posedge aclk) disable iff (!aresetn)
        s_axil_awready == s_axil_wready) else protocol_fail("awready and wready split");
    arready_once: assert property (@(posedge aclk) disable iff (!aresetn)
        s_axil_arready |=> !s_axil_arready) else protocol_fail("arready high two cycles");
    bvalid_hold: assert property (@(posedge aclk) disable iff (!aresetn)
        s_axil_bvalid && !s_axil_bready |=> s_axil_bvalid)
        else protocol_fail("bvalid dropped before bready");
    rvalid_hold: assert property (@(posedge aclk) disable iff (!aresetn)
        s_axil_rvalid && !s_axil_rready |=> s_axil_rvalid && $stable(s_axil_rdata))
        else protocol_fail("read data changed or dropped before rready");
    ireq_hold: assert property (@(posedge aclk) disable iff (!aresetn)
        ireq_tvalid && !ireq_tready |=> ireq_tvalid && $stable(ireq_beat))
        else protocol_fail("ireq beat changed or dropped before tready");

    // ireq handshakes, sampled mid-cycle
    always @(negedge aclk) begin
        if (aresetn && ireq_tvalid && ireq_tready) begin
            ireq_count++;
        end
    end

    //////////////////////////////////////////////////
    // bus tasks, entered and left 2 ns after an edge
    //////////////////////////////////////////////////

    task automatic axil_write(input logic [3:0] addr, input logic [31:0] data,
                              input logic [3:0] strb);
        int n;
        int gap;
        s_axil_awaddr  = addr;
        s_axil_wdata   = data;
        s_axil_wstrb   = strb;
        s_axil_awvalid = 1'b1;
        s_axil_wvalid  = 1'b1;
        n = 0;
        do begin
            @(negedge aclk);
            n++;
        end while (!s_axil_awready && n < WAIT_LIMIT);
        if (!s_axil_awready) begin
            wait_expired("awready never pulsed on a write");
        end
        @(posedge aclk);
        #2;
        s_axil_awvalid = 1'b0;
        s_axil_wvalid  = 1'b0;
        // bready held off for at least one cycle of bvalid
        gap = 1 + rand_bits(2);
        repeat (gap) @(posedge aclk);
        #2;
        s_axil_bready  = 1'b1;
        n = 0;
        do begin
            @(negedge aclk);
            n++;
        end while (!s_axil_bvalid && n < WAIT_LIMIT);
        if (!s_axil_bvalid) begin
            wait_expired("bvalid never rose after a write");
        end else begin
            check_value("write bresp", AXI_OKAY, s_axil_bresp);
        end
        @(posedge aclk);
        #2;
        s_axil_bready = 1'b0;
    endtask

    task automatic axil_read(input logic [3:0] addr, output logic [31:0] data);
        int n;
        int gap;
        data           = '0;
        s_axil_araddr  = addr;
        s_axil_arvalid = 1'b1;
        n = 0;
        do begin
            @(negedge aclk);
            n++;
        end while (!s_axil_arready && n < WAIT_LIMIT);
        if (!s_axil_arready) begin
            wait_expired("arready never pulsed on a read");
        end
        @(posedge aclk);
        #2;
        s_axil_arvalid = 1'b0;
        // rready held off for at least one cycle of rvalid
        gap = 1 + rand_bits(2);
        repeat (gap) @(posedge aclk);
        #2;
        s_axil_rready  = 1'b1;
        n = 0;
        do begin
            @(negedge aclk);
            n++;
        end while (!s_axil_rvalid && n < WAIT_LIMIT);
        if (!s_axil_rvalid) begin
            wait_expired("rvalid never rose after a read");
        end else begin
            data = s_axil_rdata;
            check_value("read rresp", AXI_OKAY, s_axil_rresp);
        end
        @(posedge aclk);
        #2;
        s_axil_rready = 1'b0;
    endtask

    // take one ireq beat, tready withheld at random
    task automatic collect_ireq(output srio_beat_t beat);
        int   n;
        logic got;
        n    = 0;
        got  = 1'b0;
        beat = '0;
        while (!got && n < WAIT_LIMIT) begin
            // first cycle is always back-pressured
            ireq_tready = (n > 0) && (rand_bits(1) != 0);
            @(negedge aclk);
            if (ireq_tvalid && ireq_tready) begin
                beat = ireq_beat;
                got  = 1'b1;
            end
            @(posedge aclk);
            #2;
            n++;
        end
        ireq_tready = 1'b0;
        if (!got) begin
            wait_expired("no ireq beat was accepted");
        end
    endtask

    task automatic send_resp(input logic [3:0] ftype, input logic [7:0] tid,
                             input logic [3:0] status);
        int n;
        iresp_beat             = '0;
        iresp_beat.tdata.tid   = tid;
        iresp_beat.tdata.ftype = ftype_e'(ftype);
        iresp_beat.tdata.ttype = status;
        iresp_beat.tkeep       = 8'hFF;
        iresp_beat.tlast       = 1'b1;
        iresp_tvalid           = 1'b1;
        n = 0;
        do begin
            @(negedge aclk);
            n++;
        end while (!iresp_tready && n < WAIT_LIMIT);
        if (!iresp_tready) begin
            wait_expired("iresp_tready never rose for a response beat");
        end
        @(posedge aclk);
        #2;
        iresp_tvalid = 1'b0;
    endtask

    // response stage drops tready once the match is taken
    task automatic wait_resp_idle();
        int n;
        n = 0;
        do begin
            @(negedge aclk);
            n++;
        end while (iresp_tready && n < WAIT_LIMIT);
        if (iresp_tready) begin
            wait_expired("response stage never completed");
        end
        @(posedge aclk);
        #2;
    endtask

    //////////////////////////////////////////////////
    // test sequence
    //////////////////////////////////////////////////

    initial begin
        lfsr_state     = LFSR_SEED;
        aresetn        = 1'b0;
        s_axil_awaddr  = '0;
        s_axil_awprot  = '0;
        s_axil_awvalid = 1'b0;
        s_axil_wdata   = '0;
        s_axil_wstrb   = '0;
        s_axil_wvalid  = 1'b0;
        s_axil_bready  = 1'b0;
        s_axil_araddr  = '0;
        s_axil_arprot  = '0;
        s_axil_arvalid = 1'b0;
        s_axil_rready  = 1'b0;
        ireq_tready    = 1'b0;
        iresp_tvalid   = 1'b0;
        iresp_beat     = '0;
        repeat (4) @(posedge aclk);
        #2;
        aresetn = 1'b1;

        // 1. reset state
        check_value("reset control outputs", 7'b0, {s_axil_awready, s_axil_wready,
                    s_axil_bvalid, s_axil_arready, s_axil_rvalid, ireq_tvalid, iresp_tready});
        axil_read(4'h0, rd_val);
        check_value("reset ctrl", 32'h0, rd_val);
        axil_read(4'h4, rd_val);
        check_value("reset dbinfo", 32'h0, rd_val);
        axil_read(4'h8, rd_val);
        check_value("reset status", 32'h0, rd_val);
        axil_read(4'hC, rd_val);
        check_value("reset rsvd", 32'h0, rd_val);

        // 2. byte strobes on dbinfo, rsvd ignores writes
        info_model = 16'(rand_bits(16));
        axil_write(4'h4, {16'h0, info_model}, 4'hF);
        axil_read(4'h4, rd_val);
        check_value("dbinfo full write", {16'h0, info_model}, rd_val);
        wr_val = rand_bits(32);
        axil_write(4'h4, wr_val, 4'b0010);
        info_model[15:8] = wr_val[15:8];
        axil_read(4'h4, rd_val);
        check_value("dbinfo upper byte strobe", {16'h0, info_model}, rd_val);
        wr_val = rand_bits(32);
        axil_write(4'h4, wr_val, 4'b1101);
        info_model[7:0] = wr_val[7:0];
        axil_read(4'h4, rd_val);
        check_value("dbinfo lower byte strobe", {16'h0, info_model}, rd_val);
        axil_write(4'hC, 32'hFFFF_FFFF, 4'hF);
        axil_read(4'hC, rd_val);
        check_value("rsvd after write", 32'h0, rd_val);

        // 3. first doorbell
        axil_write(4'h0, 32'h1, 4'h1);
        collect_ireq(got_beat);
        check_value("doorbell 0 header", {8'd0, FTYPE_DOORBELL, 4'h0, 2'd1, 1'b0, 13'd0,
                    info_model, 16'h0}, got_beat.tdata);
        check_value("doorbell 0 tkeep", 8'hFF, got_beat.tkeep);
        check_value("doorbell 0 tlast", 1'b1, got_beat.tlast);
        check_value("doorbell 0 tuser", {DEV_ID, DEST_ID}, got_beat.tuser);
        check_value("doorbell 0 tvalid after accept", 1'b0, ireq_tvalid);
        check_value("doorbell 0 beat count", 1, ireq_count);

        // 4. stray beats dropped, then the match
        send_resp(FTYPE_RESPONSE, 8'h05, ST_DONE);
        send_resp(FTYPE_DOORBELL, 8'h00, ST_DONE);
        check_value("still waiting after stray beats", 1'b1, iresp_tready);
        axil_read(4'h0, rd_val);
        check_value("ctrl held by stray beats", 32'h1, rd_val);
        send_resp(FTYPE_RESPONSE, 8'h00, ST_DONE);
        wait_resp_idle();
        axil_read(4'h0, rd_val);
        check_value("ctrl after done", 32'h0, rd_val);
        axil_read(4'h8, rd_val);
        check_value("status after done", {16'h0, 8'd0, 4'd0, 2'b00, 1'b0, 1'b1}, rd_val);

        // 5. second doorbell answered with an error
        info_model = 16'(rand_bits(16));
        axil_write(4'h4, {16'h0, info_model}, 4'h3);
        axil_write(4'h0, 32'h1, 4'h1);
        collect_ireq(got_beat);
        check_value("doorbell 1 header", {8'd1, FTYPE_DOORBELL, 4'h0, 2'd1, 1'b0, 13'd0,
                    info_model, 16'h0}, got_beat.tdata);
        check_value("doorbell 1 beat count", 2, ireq_count);
        axil_read(4'h8, rd_val);
        check_value("status done cleared by start", 32'h0, rd_val);
        send_resp(FTYPE_RESPONSE, 8'h01, ST_ERROR);
        wait_resp_idle();
        axil_read(4'h0, rd_val);
        check_value("ctrl after error", 32'h0, rd_val);
        axil_read(4'h8, rd_val);
        check_value("status after error", {16'h0, 8'd1, 4'd7, 2'b00, 1'b1, 1'b1}, rd_val);
        check_value("final beat count", 2, ireq_count);

        repeat (2) @(posedge aclk);
        $display("errors: mismatch %0d, protocol %0d, timeout %0d",
                 mismatch_errs, protocol_errs, timeout_errs);
        if (mismatch_errs == 0 && protocol_errs == 0 && timeout_errs == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// File: verilog/srio_trc_top.sv
`timescale 1ns/1ns

module srio_trc_top
    import trc_pkg::*;
(
    input  logic                 aclk,
    input  logic                 aresetn,

    input  logic [AXIL_AW-1:0]   s_axil_awaddr,
    input  logic [2:0]           s_axil_awprot,
    input  logic                 s_axil_awvalid,
    output logic                 s_axil_awready,
    input  logic [AXIL_DW-1:0]   s_axil_wdata,
    input  logic [AXIL_DW/8-1:0] s_axil_wstrb,
    input  logic                 s_axil_wvalid,
    output logic                 s_axil_wready,
    output logic [1:0]           s_axil_bresp,
    output logic                 s_axil_bvalid,
    input  logic                 s_axil_bready,
    input  logic [AXIL_AW-1:0]   s_axil_araddr,
    input  logic [2:0]           s_axil_arprot,
    input  logic                 s_axil_arvalid,
    output logic                 s_axil_arready,
    output logic [AXIL_DW-1:0]   s_axil_rdata,
    output logic [1:0]           s_axil_rresp,
    output logic                 s_axil_rvalid,
    input  logic                 s_axil_rready,

    output logic                 ireq_tvalid,
    input  logic                 ireq_tready,
    output srio_beat_t           ireq_beat,

    input  logic                 iresp_tvalid,
    output logic                 iresp_tready,
    input  srio_beat_t           iresp_beat
);

    logic        db_start;
    logic [15:0] db_info;
    logic        req_sent;
    logic [7:0]  sent_tid;
    logic        db_done;
    db_done_t    done_rec;

    // host registers, start edge and status
    trc_axil_regs u_regs (
        .aclk           (aclk),
        .aresetn        (aresetn),
        .s_axil_awaddr  (s_axil_awaddr),
        .s_axil_awprot  (s_axil_awprot),
        .s_axil_awvalid (s_axil_awvalid),
        .s_axil_awready (s_axil_awready),
        .s_axil_wdata   (s_axil_wdata),
        .s_axil_wstrb   (s_axil_wstrb),
        .s_axil_wvalid  (s_axil_wvalid),
        .s_axil_wready  (s_axil_wready),
        .s_axil_bresp   (s_axil_bresp),
        .s_axil_bvalid  (s_axil_bvalid),
        .s_axil_bready  (s_axil_bready),
        .s_axil_araddr  (s_axil_araddr),
        .s_axil_arprot  (s_axil_arprot),
        .s_axil_arvalid (s_axil_arvalid),
        .s_axil_arready (s_axil_arready),
        .s_axil_rdata   (s_axil_rdata),
        .s_axil_rresp   (s_axil_rresp),
        .s_axil_rvalid  (s_axil_rvalid),
        .s_axil_rready  (s_axil_rready),
        .db_done        (db_done),
        .done_rec       (done_rec),
        .db_start       (db_start),
        .db_info        (db_info)
    );

    trc_db_request u_req (
        .aclk        (aclk),
        .aresetn     (aresetn),
        .db_start    (db_start),
        .db_info     (db_info),
        .ireq_tvalid (ireq_tvalid),
        .ireq_beat   (ireq_beat),
        .ireq_tready (ireq_tready),
        .req_sent    (req_sent),
        .sent_tid    (sent_tid)
    );

    trc_db_response u_resp (
        .aclk         (aclk),
        .aresetn      (aresetn),
        .req_sent     (req_sent),
        .sent_tid     (sent_tid),
        .iresp_tvalid (iresp_tvalid),
        .iresp_beat   (iresp_beat),
        .iresp_tready (iresp_tready),
        .db_done      (db_done),
        .done_rec     (done_rec)
    );

endmodule

// File: verilog/trc_axil_regs.sv
`timescale 1ns/1ns

module trc_axil_regs
    import trc_pkg::*;
(
    input  logic                 aclk,
    input  logic                 aresetn,

    input  logic [AXIL_AW-1:0]   s_axil_awaddr,
    input  logic [2:0]           s_axil_awprot,
    input  logic                 s_axil_awvalid,
    output logic                 s_axil_awready,
    input  logic [AXIL_DW-1:0]   s_axil_wdata,
    input  logic [AXIL_DW/8-1:0] s_axil_wstrb,
    input  logic                 s_axil_wvalid,
    output logic                 s_axil_wready,
    output logic [1:0]           s_axil_bresp,
    output logic                 s_axil_bvalid,
    input  logic                 s_axil_bready,
    input  logic [AXIL_AW-1:0]   s_axil_araddr,
    input  logic [2:0]           s_axil_arprot,
    input  logic                 s_axil_arvalid,
    output logic                 s_axil_arready,
    output logic [AXIL_DW-1:0]   s_axil_rdata,
    output logic [1:0]           s_axil_rresp,
    output logic                 s_axil_rvalid,
    input  logic                 s_axil_rready,

    input  logic                 db_done,
    input  db_done_t             done_rec,
    output logic                 db_start,
    output logic [15:0]          db_info
);

    logic             wr_ready;
    logic             wr_idle;
    logic             wr_en;
    reg_addr_e        wr_idx;
    logic             bvalid_q;
    logic             arready_q;
    logic             rvalid_q;
    logic             rd_en;
    reg_addr_e        rd_idx;
    logic [AXIL_DW-1:0] rd_word;
    logic [AXIL_DW-1:0] rdata_q;

    logic             start_bit;
    logic             start_q;
    logic [15:0]      dbinfo_q;
    logic             status_done;
    db_done_t         status_rec;

    //////////////////////////////////////////////////
    // write channel
    //////////////////////////////////////////////////

    // aw and w are taken together, one cycle ready pulse
    assign s_axil_awready = wr_ready;
    assign s_axil_wready  = wr_ready;
    assign s_axil_bvalid  = bvalid_q;
    assign s_axil_bresp   = AXI_OKAY;

    // master holds aw/w valid until ready
    assign wr_en  = wr_ready & s_axil_awvalid & s_axil_wvalid;
    assign wr_idx = reg_addr_e'(s_axil_awaddr[AXIL_AW-1:2]);

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            wr_idle  <= 1'b1;
            wr_ready <= 1'b0;
        end else begin
            wr_ready <= s_axil_awvalid && s_axil_wvalid && wr_idle;
            // locked from acceptance until the b handshake
            if (s_axil_awvalid && s_axil_wvalid && wr_idle) begin
                wr_idle <= 1'b0;
            end else if (bvalid_q && s_axil_bready) begin
                wr_idle <= 1'b1;
            end
        end
    end

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            bvalid_q <= 1'b0;
        end else if (wr_en) begin
            bvalid_q <= 1'b1;
        end else if (s_axil_bready) begin
            bvalid_q <= 1'b0;
        end
    end

    //////////////////////////////////////////////////
    // registers
    //////////////////////////////////////////////////

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            start_bit <= 1'b0;
            dbinfo_q  <= '0;
        end else begin
            if (wr_en) begin
                case (wr_idx)
                    REG_CTRL: begin
                        if (s_axil_wstrb[0]) begin
                            start_bit <= s_axil_wdata[0];
                        end
                    end
                    REG_DBINFO: begin
                        for (int i = 0; i < 2; i++) begin
                            if (s_axil_wstrb[i]) begin
                                dbinfo_q[i*8 +: 8] <= s_axil_wdata[i*8 +: 8];
                            end
                        end
                    end
                    // status is read only, rsvd ignores writes
                    default: ;
                endcase
            end
            // completion wins over a host write in the same cycle
            if (db_done) begin
                start_bit <= 1'b0;
            end
        end
    end

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            status_done <= 1'b0;
            status_rec  <= '0;
        end else begin
            if (db_start) begin
                status_done <= 1'b0;
            end
            if (db_done) begin
                status_done <= 1'b1;
                status_rec  <= done_rec;
            end
        end
    end

    // rising edge of the start bit
    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            start_q <= 1'b0;
        end else begin
            start_q <= start_bit;
        end
    end

    assign db_start = start_bit & ~start_q;
    assign db_info  = dbinfo_q;

    //////////////////////////////////////////////////
    // read channel
    //////////////////////////////////////////////////

    assign s_axil_arready = arready_q;
    assign s_axil_rvalid  = rvalid_q;
    assign s_axil_rdata   = rdata_q;
    assign s_axil_rresp   = AXI_OKAY;

    assign rd_en  = arready_q & s_axil_arvalid;
    assign rd_idx = reg_addr_e'(s_axil_araddr[AXIL_AW-1:2]);

    always_comb begin
        rd_word = '0;
        case (rd_idx)
            REG_CTRL:   rd_word[0] = start_bit;
            REG_DBINFO: rd_word[15:0] = dbinfo_q;
            REG_STATUS: begin
                rd_word[0]    = status_done;
                rd_word[1]    = status_rec.error;
                rd_word[7:4]  = status_rec.status;
                rd_word[15:8] = status_rec.tid;
            end
            default: rd_word = '0;
        endcase
    end

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            arready_q <= 1'b0;
            rvalid_q  <= 1'b0;
        end else begin
            // no new address while a read beat is pending
            arready_q <= !arready_q && s_axil_arvalid && !rvalid_q;
            if (rd_en) begin
                rvalid_q <= 1'b1;
            end else if (s_axil_rready) begin
                rvalid_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (rd_en) begin
            rdata_q <= rd_word;
        end
    end

    // ready is a single-cycle pulse
    awready_pulse: assert property (@(posedge aclk) disable iff (!aresetn)
        s_axil_awready |=> !s_axil_awready);

endmodule

// File: verilog/trc_db_request.sv
`timescale 1ns/1ns

module trc_db_request
    import trc_pkg::*;
(
    input  logic        aclk,
    input  logic        aresetn,
    input  logic        db_start,
    input  logic [15:0] db_info,

    output logic        ireq_tvalid,
    output srio_beat_t  ireq_beat,
    input  logic        ireq_tready,

    output logic        req_sent,
    output logic [7:0]  sent_tid
);

    logic       handshake;
    logic       load;
    logic [7:0] tid_cnt;
    srio_hdr_t  hdr_next;

    assign handshake = ireq_tvalid & ireq_tready;
    // a start while a beat is still out is not taken
    assign load = db_start & ~ireq_tvalid;

    // doorbell header, unnamed fields zero
    always_comb begin
        hdr_next       = '0;
        hdr_next.tid   = tid_cnt;
        hdr_next.ftype = FTYPE_DOORBELL;
        hdr_next.prio  = DB_PRIO;
        hdr_next.info  = db_info;
    end

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            ireq_tvalid <= 1'b0;
        end else if (load) begin
            ireq_tvalid <= 1'b1;
        end else if (handshake) begin
            ireq_tvalid <= 1'b0;
        end
    end

    // beat held until accepted
    always_ff @(posedge aclk) begin
        if (load) begin
            ireq_beat <= '{
                tdata: hdr_next,
                tkeep: TKEEP_ALL,
                tlast: 1'b1,
                tuser: {DEV_ID, DEST_ID}
            };
        end
    end

    // doorbells sent since reset, wraps at 256
    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            tid_cnt <= '0;
        end else if (handshake) begin
            tid_cnt <= tid_cnt + 8'd1;
        end
    end

    assign req_sent = handshake;
    assign sent_tid = ireq_beat.tdata.tid;

    beat_hold: assert property (@(posedge aclk) disable iff (!aresetn)
        ireq_tvalid && !ireq_tready |=> ireq_tvalid && $stable(ireq_beat));

endmodule

// File: verilog/trc_db_response.sv
`timescale 1ns/1ns

module trc_db_response
    import trc_pkg::*;
(
    input  logic       aclk,
    input  logic       aresetn,
    input  logic       req_sent,
    input  logic [7:0] sent_tid,

    input  logic       iresp_tvalid,
    input  srio_beat_t iresp_beat,
    output logic       iresp_tready,

    output logic       db_done,
    output db_done_t   done_rec
);

    rsp_state_e   state;
    logic [7:0]   exp_tid;
    logic         accept;
    logic         match;
    resp_status_e rsp_status;

    // ready only while waiting
    assign iresp_tready = (state == RSP_WAIT);
    assign accept       = iresp_tvalid & iresp_tready;

    // other ftypes and stale tids fall through and are dropped
    assign match = accept
                 && (iresp_beat.tdata.ftype == FTYPE_RESPONSE)
                 && (iresp_beat.tdata.tid == exp_tid);

    assign rsp_status = resp_status_e'(iresp_beat.tdata.ttype);

    //////////////////////////////////////////////////
    // wait FSM
    //////////////////////////////////////////////////

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            state <= RSP_IDLE;
        end else begin
            case (state)
                RSP_IDLE: begin
                    if (req_sent) begin
                        state <= RSP_WAIT;
                    end
                end
                RSP_WAIT: begin
                    if (match) begin
                        state <= RSP_IDLE;
                    end
                end
                default: state <= RSP_IDLE;
            endcase
        end
    end

    always_ff @(posedge aclk) begin
        if (req_sent) begin
            exp_tid <= sent_tid;
        end
    end

    //////////////////////////////////////////////////
    // completion
    //////////////////////////////////////////////////

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            db_done <= 1'b0;
        end else begin
            db_done <= match;
        end
    end

    always_ff @(posedge aclk) begin
        if (match) begin
            done_rec.tid    <= iresp_beat.tdata.tid;
            done_rec.status <= rsp_status;
            done_rec.error  <= (rsp_status != ST_DONE);
        end
    end

    // one doorbell outstanding at a time
    single_outstanding: assert property (@(posedge aclk) disable iff (!aresetn)
        req_sent |-> state == RSP_IDLE);

endmodule

// File: verilog/trc_pkg.sv
package trc_pkg;

    //////////////////////////////////////////////////
    // ids and bus widths
    //////////////////////////////////////////////////

    // own device and the far end
    localparam logic [15:0] DEV_ID  = 16'hF201;
    localparam logic [15:0] DEST_ID = 16'h7801;

    localparam int AXIL_DW = 32;
    localparam int AXIL_AW = 4;

    // OKAY response on b and r channels
    localparam logic [1:0] AXI_OKAY = 2'b00;

    // every byte of a 64-bit beat is valid
    localparam logic [7:0] TKEEP_ALL = 8'hFF;

    // doorbell priority
    localparam logic [1:0] DB_PRIO = 2'd1;

    //////////////////////////////////////////////////
    // encodings
    //////////////////////////////////////////////////

    // register index, address bits 3:2
    typedef enum logic [1:0] {
        REG_CTRL   = 2'd0,
        REG_DBINFO = 2'd1,
        REG_STATUS = 2'd2,
        REG_RSVD   = 2'd3
    } reg_addr_e;

    typedef enum logic [3:0] {
        FTYPE_DOORBELL = 4'hA,
        FTYPE_RESPONSE = 4'hD
    } ftype_e;

    // carried in ttype of a response
    typedef enum logic [3:0] {
        ST_DONE  = 4'd0,
        ST_ERROR = 4'd7
    } resp_status_e;

    // response stage, idle or waiting for a matching tid
    typedef enum logic [0:0] {
        RSP_IDLE = 1'b0,
        RSP_WAIT = 1'b1
    } rsp_state_e;

    //////////////////////////////////////////////////
    // packet and beat layouts
    //////////////////////////////////////////////////

    // 64-bit header, msb first
    typedef struct packed {
        logic [7:0]  tid;
        ftype_e      ftype;
        logic [3:0]  ttype;
        logic [1:0]  prio;
        logic        crf;
        logic [12:0] rsvd_a;
        logic [15:0] info;
        logic [15:0] rsvd_b;
    } srio_hdr_t;

    typedef struct packed {
        srio_hdr_t   tdata;
        logic [7:0]  tkeep;
        logic        tlast;
        logic [31:0] tuser;
    } srio_beat_t;

    // completion record handed back to the registers
    typedef struct packed {
        logic [7:0]   tid;
        resp_status_e status;
        logic         error;
    } db_done_t;

endpackage
